/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exec
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 4

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_exec.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_exec;

    localparam int wait_limit = 200;

    logic                     clk;
    logic                     reset_n;
    logic                     in_valid_i;
    logic                     in_ready_o;
    exec_bus_pkg::exec_req_t  req_i;
    logic                     out_valid_o;
    logic                     out_ready_i;
    exec_bus_pkg::exec_rsp_t  rsp_o;
    integer                   seed;
    exec_bus_pkg::exec_rsp_t  expected_q[$];

    exec_top u_exec_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .req_i        (req_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .rsp_o        (rsp_o)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic exec_bus_pkg::exec_req_t make_req(input exec_op_pkg::exec_op_e op,
            input logic [31:0] rs1, input logic [31:0] rs2, input logic [31:0] op2,
            input logic [4:0] rd);
        exec_bus_pkg::exec_req_t r;
        r.op         = op;
        r.pc         = rand_word() & 32'hffff_fffc;
        r.rs1_data   = rs1;
        r.rs2_data   = rs2;
        r.operand2   = op2;
        r.rd         = rd;
        r.compressed = 1'b0;
        r.imm_target = r.pc + (rand_word() & 32'h0000_0ffe);
        return r;
    endfunction

    // Expected response from the execute rules
    function automatic exec_bus_pkg::exec_rsp_t expected_rsp(input exec_bus_pkg::exec_req_t r);
        exec_bus_pkg::exec_rsp_t e;
        logic [31:0]             sum;
        logic                    no_write;
        sum = r.rs1_data + r.operand2;
        case (r.op)
            exec_op_pkg::SUB:   e.result = r.rs1_data - r.operand2;
            exec_op_pkg::SLT:   e.result = {31'd0, $signed(r.rs1_data) < $signed(r.operand2)};
            exec_op_pkg::SLTU:  e.result = {31'd0, r.rs1_data < r.operand2};
            exec_op_pkg::XOR:   e.result = r.rs1_data ^ r.operand2;
            exec_op_pkg::OR:    e.result = r.rs1_data | r.operand2;
            exec_op_pkg::AND:   e.result = r.rs1_data & r.operand2;
            exec_op_pkg::SLL:   e.result = r.rs1_data << r.operand2[4:0];
            exec_op_pkg::SRL:   e.result = r.rs1_data >> r.operand2[4:0];
            exec_op_pkg::SRA:   e.result = $signed(r.rs1_data) >>> r.operand2[4:0];
            exec_op_pkg::LUI:   e.result = r.operand2;
            exec_op_pkg::AUIPC: e.result = r.imm_target;
            exec_op_pkg::JAL,
            exec_op_pkg::JALR:  e.result = r.pc + (r.compressed ? 32'd2 : 32'd4);
            default:            e.result = sum;
        endcase
        no_write = r.op inside {exec_op_pkg::NOP, exec_op_pkg::SB, exec_op_pkg::SH,
            exec_op_pkg::SW, exec_op_pkg::BEQ, exec_op_pkg::BNE, exec_op_pkg::BLT,
            exec_op_pkg::BLTU, exec_op_pkg::BGE, exec_op_pkg::BGEU};
        e.rd           = r.rd;
        e.write_enable = (r.rd != 5'd0) && !no_write;
        e.mem.addr     = {sum[31:2], 2'b00};
        e.mem.read     = r.op inside {exec_op_pkg::LB, exec_op_pkg::LBU, exec_op_pkg::LH,
            exec_op_pkg::LHU, exec_op_pkg::LW};
        case (r.op)
            exec_op_pkg::SB: e.mem.wstrb = 4'b0001 << sum[1:0];
            exec_op_pkg::SH: e.mem.wstrb = sum[1] ? 4'b1100 : 4'b0011;
            exec_op_pkg::SW: e.mem.wstrb = 4'b1111;
            default:         e.mem.wstrb = 4'b0000;
        endcase
        case (r.op)
            exec_op_pkg::SB: e.mem.wdata = {4{r.rs2_data[7:0]}};
            exec_op_pkg::SH: e.mem.wdata = {2{r.rs2_data[15:0]}};
            default:         e.mem.wdata = r.rs2_data;
        endcase
        case (r.op)
            exec_op_pkg::BEQ:  e.jump = r.rs1_data == r.operand2;
            exec_op_pkg::BNE:  e.jump = r.rs1_data != r.operand2;
            exec_op_pkg::BLT:  e.jump = $signed(r.rs1_data) < $signed(r.operand2);
            exec_op_pkg::BLTU: e.jump = r.rs1_data < r.operand2;
            exec_op_pkg::BGE:  e.jump = $signed(r.rs1_data) >= $signed(r.operand2);
            exec_op_pkg::BGEU: e.jump = r.rs1_data >= r.operand2;
            exec_op_pkg::JAL,
            exec_op_pkg::JALR: e.jump = 1'b1;
            default:           e.jump = 1'b0;
        endcase
        e.jump_target = (r.op == exec_op_pkg::JALR) ? {sum[31:1], 1'b0} : r.imm_target;
        return e;
    endfunction

    ////////////////////////////////////////
    // Checks and handshake helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [255:0] expected,
            input logic [255:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    // Holds in_valid_i until the request is taken, returns 1 ns after that edge
    task automatic send_request(input exec_bus_pkg::exec_req_t r);
        int cycles;
        cycles     = 0;
        in_valid_i = 1'b1;
        req_i      = r;
        @(negedge clk);
        while (!in_ready_o) begin
            cycles++;
            if (cycles > wait_limit) begin
                report_failure("Timed out waiting for the stage to accept the request");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid_i = 1'b0;
    endtask

    task automatic wait_response();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!out_valid_o) begin
            cycles++;
            if (cycles > wait_limit) begin
                report_failure("Timed out waiting for a response from the stage");
            end
            @(negedge clk);
        end
    endtask

    task automatic run_single(input string name, input exec_bus_pkg::exec_req_t r);
        send_request(r);
        wait_response();
        check_value(name, 256'(expected_rsp(r)), 256'(rsp_o));
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic reset_state_test();
        @(negedge clk);
        check_value("reset out_valid", 256'(1'b0), 256'(out_valid_o));
        check_value("reset in_ready", 256'(1'b1), 256'(in_ready_o));
        check_value("reset rsp", 256'(0), 256'(rsp_o));
        @(posedge clk);
        #1;
    endtask

    task automatic alu_test();
        exec_op_pkg::exec_op_e ops[12];
        logic [31:0]           rnd;
        ops = '{exec_op_pkg::ADD, exec_op_pkg::SUB, exec_op_pkg::SLT, exec_op_pkg::SLTU,
                exec_op_pkg::XOR, exec_op_pkg::OR, exec_op_pkg::AND, exec_op_pkg::SLL,
                exec_op_pkg::SRL, exec_op_pkg::SRA, exec_op_pkg::LUI, exec_op_pkg::AUIPC};
        for (int i = 0; i < 12; i++) begin
            for (int n = 0; n < 4; n++) begin
                rnd = rand_word();
                run_single($sformatf("alu %s", ops[i].name()), make_req(ops[i], rand_word(),
                    rand_word(), rand_word(), rnd[4:0] | 5'd1));
            end
        end
        // Writes to x0 are dropped
        run_single("alu rd zero", make_req(exec_op_pkg::ADD, 32'd7, 32'd0, 32'd9, 5'd0));
        check_value("alu rd zero write_enable", 256'(1'b0), 256'(rsp_o.write_enable));
    endtask

    task automatic branch_jump_test();
        exec_op_pkg::exec_op_e   ops[6];
        logic [31:0]             lhs[3];
        logic [31:0]             rhs[3];
        logic [5:0]              taken[3];
        exec_bus_pkg::exec_req_t r;
        ops   = '{exec_op_pkg::BEQ, exec_op_pkg::BNE, exec_op_pkg::BLT, exec_op_pkg::BLTU,
                  exec_op_pkg::BGE, exec_op_pkg::BGEU};
        // Equal, less-than and greater pairs; bit i is the outcome for ops[i]
        lhs   = '{32'h0000_1234, 32'h0000_0010, 32'h0000_0020};
        rhs   = '{32'h0000_1234, 32'h0000_0020, 32'h0000_0010};
        taken = '{6'b110001, 6'b001110, 6'b110010};
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 3; p++) begin
                r = make_req(ops[i], lhs[p], rand_word(), rhs[p], 5'd3);
                run_single($sformatf("branch %s", ops[i].name()), r);
                check_value("branch jump", 256'(taken[p][i]), 256'(rsp_o.jump));
                check_value("branch write_enable", 256'(1'b0), 256'(rsp_o.write_enable));
            end
        end
        for (int c = 0; c < 2; c++) begin
            r = make_req(exec_op_pkg::JAL, rand_word(), rand_word(), rand_word(), 5'd1);
            r.compressed = c[0];
            run_single("jal", r);
            check_value("jal link", 256'(r.pc + (c[0] ? 32'd2 : 32'd4)), 256'(rsp_o.result));
            check_value("jal target", 256'(r.imm_target), 256'(rsp_o.jump_target));
            r = make_req(exec_op_pkg::JALR, 32'h0000_4000, 32'd0, 32'h0000_0123, 5'd1);
            r.compressed = c[0];
            run_single("jalr", r);
            check_value("jalr link", 256'(r.pc + (c[0] ? 32'd2 : 32'd4)), 256'(rsp_o.result));
            check_value("jalr target", 256'(32'h0000_4122), 256'(rsp_o.jump_target));
        end
    endtask

    task automatic load_store_test();
        exec_op_pkg::exec_op_e loads[5];
        logic [31:0]           base;
        loads = '{exec_op_pkg::LB, exec_op_pkg::LBU, exec_op_pkg::LH, exec_op_pkg::LHU,
                  exec_op_pkg::LW};
        base  = rand_word() & 32'hffff_fffc;
        for (int off = 0; off < 4; off++) begin
            run_single("store SB", make_req(exec_op_pkg::SB, base, 32'ha1b2_c3d4, 32'(off), 5'd0));
            check_value("SB wstrb", 256'(4'b0001 << off), 256'(rsp_o.mem.wstrb));
            check_value("SB wdata", 256'(32'hd4d4_d4d4), 256'(rsp_o.mem.wdata));
            check_value("SB addr", 256'(base), 256'(rsp_o.mem.addr));
        end
        run_single("store SH", make_req(exec_op_pkg::SH, base, 32'ha1b2_c3d4, 32'd0, 5'd0));
        check_value("SH low wstrb", 256'(4'b0011), 256'(rsp_o.mem.wstrb));
        check_value("SH wdata", 256'(32'hc3d4_c3d4), 256'(rsp_o.mem.wdata));
        run_single("store SH", make_req(exec_op_pkg::SH, base, 32'ha1b2_c3d4, 32'd2, 5'd0));
        check_value("SH high wstrb", 256'(4'b1100), 256'(rsp_o.mem.wstrb));
        run_single("store SW", make_req(exec_op_pkg::SW, base, 32'ha1b2_c3d4, 32'd3, 5'd0));
        check_value("SW wstrb", 256'(4'b1111), 256'(rsp_o.mem.wstrb));
        check_value("SW addr", 256'(base), 256'(rsp_o.mem.addr));
        for (int i = 0; i < 5; i++) begin
            run_single($sformatf("load %s", loads[i].name()),
                make_req(loads[i], base, rand_word(), 32'd5, 5'd9));
            check_value("load read", 256'(1'b1), 256'(rsp_o.mem.read));
            check_value("load wstrb", 256'(4'b0000), 256'(rsp_o.mem.wstrb));
        end
    endtask

    task automatic backpressure_test();
        exec_op_pkg::exec_op_e   ops[8];
        exec_bus_pkg::exec_req_t r;
        logic [31:0]             rnd;
        logic [31:0]             ready_rnd;
        int                      received;
        int                      cycles;
        ops = '{exec_op_pkg::ADD, exec_op_pkg::SUB, exec_op_pkg::XOR, exec_op_pkg::SLL,
                exec_op_pkg::SRA, exec_op_pkg::SW, exec_op_pkg::LW, exec_op_pkg::BNE};
        out_ready_i = 1'b0;
        r = make_req(exec_op_pkg::ADD, rand_word(), rand_word(), rand_word(), 5'd4);
        expected_q.push_back(expected_rsp(r));
        send_request(r);
        // Second request waits behind the held response
        r = make_req(exec_op_pkg::SUB, rand_word(), rand_word(), rand_word(), 5'd6);
        expected_q.push_back(expected_rsp(r));
        in_valid_i = 1'b1;
        req_i      = r;
        wait_response();
        repeat (5) begin
            @(negedge clk);
            check_value("stall out_valid", 256'(1'b1), 256'(out_valid_o));
            check_value("stall in_ready", 256'(1'b0), 256'(in_ready_o));
            check_value("stall rsp", 256'(expected_q[0]), 256'(rsp_o));
        end
        @(posedge clk);
        #1;
        fork
            begin
                send_request(r);
                for (int i = 0; i < 20; i++) begin
                    rnd = rand_word();
                    r   = make_req(ops[rnd[2:0]], rand_word(), rand_word(), rand_word(), rnd[8:4]);
                    expected_q.push_back(expected_rsp(r));
                    send_request(r);
                end
            end
            begin
                received = 0;
                cycles   = 0;
                while (received < 22) begin
                    ready_rnd   = rand_word();
                    out_ready_i = ready_rnd[16];
                    @(negedge clk);
                    if (out_valid_o && out_ready_i) begin
                        if (expected_q.size() == 0) begin
                            report_failure("Response arrived with no request outstanding");
                        end
                        check_value("stream rsp", 256'(expected_q.pop_front()), 256'(rsp_o));
                        received++;
                    end
                    cycles++;
                    if (cycles > 5 * wait_limit) begin
                        report_failure("Timed out waiting for the response stream to drain");
                    end
                    @(posedge clk);
                    #1;
                end
                out_ready_i = 1'b1;
            end
        join
    endtask

    initial begin
        seed        = 54;
        clk         = 1'b0;
        reset_n     = 1'b0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b1;
        req_i       = '0;
        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;
        reset_state_test();
        alu_test();
        branch_jump_test();
        load_store_test();
        backpressure_test();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/exec_op_pkg.sv
verilog/exec_bus_pkg.sv
verilog/exec_alu.sv
verilog/exec_lsu.sv
verilog/exec_branch.sv
verilog/exec_output_stage.sv
verilog/exec_top.sv
test/tb_exec.sv

/* verilog/exec_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_alu (
    input  exec_bus_pkg::exec_req_t        req_i,
    output logic [exec_op_pkg::xlen-1:0]   result_o
);

    logic [exec_op_pkg::xlen-1:0]     sum_result;
    logic [exec_op_pkg::xlen-1:0]     sum2_result;
    logic [exec_op_pkg::xlen-1:0]     sum2_op_a;
    logic [exec_op_pkg::xlen-1:0]     sum2_op_b;
    logic [exec_op_pkg::xlen-1:0]     link_step;
    logic [exec_op_pkg::xlen-1:0]     and_result;
    logic [exec_op_pkg::xlen-1:0]     or_result;
    logic [exec_op_pkg::xlen-1:0]     xor_result;
    logic [exec_op_pkg::xlen-1:0]     sll_result;
    logic [exec_op_pkg::xlen-1:0]     srl_result;
    logic [exec_op_pkg::xlen-1:0]     sra_result;
    logic [exec_op_pkg::shamt_w-1:0]  shamt;
    logic                             less_than;
    logic                             less_than_unsigned;

    ////////////////////////////////////////
    // Second adder
    ////////////////////////////////////////

    // Link value for jumps, difference for SUB
    assign link_step = req_i.compressed ? exec_op_pkg::link_step_short
                                        : exec_op_pkg::link_step_full;

    always_comb begin
        case (req_i.op)
            exec_op_pkg::JAL, exec_op_pkg::JALR: begin
                sum2_op_a = req_i.pc;
                sum2_op_b = link_step;
            end
            exec_op_pkg::SUB: begin
                sum2_op_a = req_i.rs1_data;
                sum2_op_b = -req_i.operand2;
            end
            default: begin
                sum2_op_a = req_i.rs1_data;
                sum2_op_b = req_i.operand2;
            end
        endcase
    end

    ////////////////////////////////////////
    // Arithmetic, logic and shifts
    ////////////////////////////////////////

    assign shamt = req_i.operand2[exec_op_pkg::shamt_w-1:0];

    always_comb begin
        sum_result         = req_i.rs1_data + req_i.operand2;
        sum2_result        = sum2_op_a + sum2_op_b;
        and_result         = req_i.rs1_data & req_i.operand2;
        or_result          = req_i.rs1_data | req_i.operand2;
        xor_result         = req_i.rs1_data ^ req_i.operand2;
        sll_result         = req_i.rs1_data << shamt;
        srl_result         = req_i.rs1_data >> shamt;
        sra_result         = $signed(req_i.rs1_data) >>> shamt;
        less_than          = $signed(req_i.rs1_data) < $signed(req_i.operand2);
        less_than_unsigned = req_i.rs1_data < req_i.operand2;
    end

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////

    always_comb begin
        case (req_i.op)
            exec_op_pkg::JAL,
            exec_op_pkg::JALR,
            exec_op_pkg::SUB:   result_o = sum2_result;
            exec_op_pkg::SLT:   result_o = {{(exec_op_pkg::xlen-1){1'b0}}, less_than};
            exec_op_pkg::SLTU:  result_o = {{(exec_op_pkg::xlen-1){1'b0}}, less_than_unsigned};
            exec_op_pkg::XOR:   result_o = xor_result;
            exec_op_pkg::OR:    result_o = or_result;
            exec_op_pkg::AND:   result_o = and_result;
            exec_op_pkg::SLL:   result_o = sll_result;
            exec_op_pkg::SRL:   result_o = srl_result;
            exec_op_pkg::SRA:   result_o = sra_result;
            exec_op_pkg::LUI:   result_o = req_i.operand2;
            exec_op_pkg::AUIPC: result_o = req_i.imm_target;
            // ADD, loads and stores
            default:            result_o = sum_result;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/exec_branch.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_branch (
    input  exec_bus_pkg::exec_req_t        req_i,
    output logic                           jump_o,
    output logic [exec_op_pkg::xlen-1:0]   jump_target_o
);

    logic [exec_op_pkg::xlen-1:0]  jalr_sum;
    logic                          equal;
    logic                          less_than;
    logic                          less_than_unsigned;

    assign equal              = req_i.rs1_data == req_i.operand2;
    assign less_than          = $signed(req_i.rs1_data) < $signed(req_i.operand2);
    assign less_than_unsigned = req_i.rs1_data < req_i.operand2;

    // Condition per branch type
    always_comb begin
        case (req_i.op)
            exec_op_pkg::BEQ:  jump_o = equal;
            exec_op_pkg::BNE:  jump_o = !equal;
            exec_op_pkg::BLT:  jump_o = less_than;
            exec_op_pkg::BLTU: jump_o = less_than_unsigned;
            exec_op_pkg::BGE:  jump_o = !less_than;
            exec_op_pkg::BGEU: jump_o = !less_than_unsigned;
            exec_op_pkg::JAL,
            exec_op_pkg::JALR: jump_o = 1'b1;
            default:           jump_o = 1'b0;
        endcase
    end

    // JALR drops bit 0, others use decode's target
    assign jalr_sum      = req_i.rs1_data + req_i.operand2;
    assign jump_target_o = (req_i.op == exec_op_pkg::JALR) ? {jalr_sum[exec_op_pkg::xlen-1:1], 1'b0}
                                                           : req_i.imm_target;

endmodule

`default_nettype wire

/* verilog/exec_bus_pkg.sv */
`default_nettype none

package exec_bus_pkg;

    ////////////////////////////////////////
    // Request into the stage
    ////////////////////////////////////////

    typedef struct packed {
        exec_op_pkg::exec_op_e                 op;
        logic [exec_op_pkg::xlen-1:0]          pc;
        logic [exec_op_pkg::xlen-1:0]          rs1_data;
        logic [exec_op_pkg::xlen-1:0]          rs2_data;
        // Immediate or rs2, picked by decode
        logic [exec_op_pkg::xlen-1:0]          operand2;
        logic [exec_op_pkg::reg_addr_w-1:0]    rd;
        logic                                  compressed;
        // pc + imm from decode
        logic [exec_op_pkg::xlen-1:0]          imm_target;
    } exec_req_t;

    ////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////

    typedef struct packed {
        logic [exec_op_pkg::xlen-1:0]          addr;
        logic                                  read;
        logic [exec_op_pkg::strb_w-1:0]        wstrb;
        logic [exec_op_pkg::xlen-1:0]          wdata;
    } mem_req_t;

    // Response out of the stage
    typedef struct packed {
        logic [exec_op_pkg::xlen-1:0]          result;
        logic [exec_op_pkg::reg_addr_w-1:0]    rd;
        logic                                  write_enable;
        mem_req_t                              mem;
        logic                                  jump;
        logic [exec_op_pkg::xlen-1:0]          jump_target;
    } exec_rsp_t;

endpackage

`default_nettype wire

/* verilog/exec_lsu.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_lsu (
    input  exec_bus_pkg::exec_req_t  req_i,
    output exec_bus_pkg::mem_req_t   mem_o
);

    logic [exec_op_pkg::xlen-1:0]  eff_addr;

    assign eff_addr   = req_i.rs1_data + req_i.operand2;
    assign mem_o.addr = {eff_addr[exec_op_pkg::xlen-1:2], 2'b00};
    assign mem_o.read = exec_op_pkg::is_load(req_i.op);

    // Byte lanes from the low address bits
    always_comb begin
        case (req_i.op)
            exec_op_pkg::SB: begin
                case (eff_addr[1:0])
                    2'b11:   mem_o.wstrb = 4'b1000;
                    2'b10:   mem_o.wstrb = 4'b0100;
                    2'b01:   mem_o.wstrb = 4'b0010;
                    default: mem_o.wstrb = 4'b0001;
                endcase
            end
            exec_op_pkg::SH: mem_o.wstrb = eff_addr[1] ? 4'b1100 : 4'b0011;
            exec_op_pkg::SW: mem_o.wstrb = 4'b1111;
            default:         mem_o.wstrb = 4'b0000;
        endcase
    end

    // Replicate so every lane sees the data
    always_comb begin
        case (req_i.op)
            exec_op_pkg::SB: mem_o.wdata = {4{req_i.rs2_data[7:0]}};
            exec_op_pkg::SH: mem_o.wdata = {2{req_i.rs2_data[15:0]}};
            default:         mem_o.wdata = req_i.rs2_data;
        endcase
    end

    // Lanes only ever open for stores
    always_comb begin
        if (mem_o.wstrb != '0) begin
            assert (exec_op_pkg::is_store(req_i.op))
                else $error("wstrb set for non-store op %s", req_i.op.name());
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_op_pkg.sv */
`default_nettype none

package exec_op_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned strb_w     = 4;
    localparam int unsigned shamt_w    = $clog2(xlen);
    localparam int unsigned op_w       = 6;

    // Link register increments
    localparam int unsigned link_step_full  = 4;
    localparam int unsigned link_step_short = 2;

    ////////////////////////////////////////
    // Operation encoding
    ////////////////////////////////////////

    typedef enum logic [op_w-1:0] {
        NOP, ADD, SUB, SLT, SLTU,
        XOR, OR, AND,
        SLL, SRL, SRA,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW
    } exec_op_e;

    ////////////////////////////////////////
    // Operation groups
    ////////////////////////////////////////

    function automatic logic is_load(exec_op_e op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    function automatic logic is_store(exec_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    // Conditional branches only, jumps not included
    function automatic logic is_branch(exec_op_e op);
        return op inside {BEQ, BNE, BLT, BLTU, BGE, BGEU};
    endfunction

endpackage

`default_nettype wire

/* verilog/exec_output_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_output_stage (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           in_valid_i,
    output logic                           in_ready_o,
    input  exec_bus_pkg::exec_req_t        req_i,
    input  logic [exec_op_pkg::xlen-1:0]   alu_result_i,
    input  exec_bus_pkg::mem_req_t         mem_i,
    input  logic                           jump_i,
    input  logic [exec_op_pkg::xlen-1:0]   jump_target_i,
    output logic                           out_valid_o,
    input  logic                           out_ready_i,
    output exec_bus_pkg::exec_rsp_t        rsp_o
);

    logic                       accept;
    logic                       write_enable;
    exec_bus_pkg::exec_rsp_t    rsp_d;

    ////////////////////////////////////////
    // Register write enable
    ////////////////////////////////////////

    assign write_enable = (req_i.rd != '0)
                       && (req_i.op != exec_op_pkg::NOP)
                       && !exec_op_pkg::is_store(req_i.op)
                       && !exec_op_pkg::is_branch(req_i.op);

    always_comb begin
        rsp_d.result       = alu_result_i;
        rsp_d.rd           = req_i.rd;
        rsp_d.write_enable = write_enable;
        rsp_d.mem          = mem_i;
        rsp_d.jump         = jump_i;
        rsp_d.jump_target  = jump_target_i;
    end

    ////////////////////////////////////////
    // Output register and handshake
    ////////////////////////////////////////

    // Ready when empty or draining this cycle
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid_o <= 1'b0;
            rsp_o       <= '0;
        end else if (accept) begin
            out_valid_o <= 1'b1;
            rsp_o       <= rsp_d;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    // Held response must not change under back-pressure
    assert property (@(posedge clk) disable iff (!reset_n)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(rsp_o))
        else $error("response changed while stalled");

    // An empty stage takes whatever is offered
    assert property (@(posedge clk) disable iff (!reset_n)
        !out_valid_o && in_valid_i |=> out_valid_o)
        else $error("empty stage did not take the request");

endmodule

`default_nettype wire

/* verilog/exec_top.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    input  exec_bus_pkg::exec_req_t    req_i,
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output exec_bus_pkg::exec_rsp_t    rsp_o
);

    logic [exec_op_pkg::xlen-1:0]  alu_result;
    exec_bus_pkg::mem_req_t        mem_req;
    logic                          jump;
    logic [exec_op_pkg::xlen-1:0]  jump_target;

    ////////////////////////////////////////
    // Combinational units
    ////////////////////////////////////////

    exec_alu u_exec_alu (
        .req_i          (req_i),
        .result_o       (alu_result)
    );

    exec_lsu u_exec_lsu (
        .req_i          (req_i),
        .mem_o          (mem_req)
    );

    exec_branch u_exec_branch (
        .req_i          (req_i),
        .jump_o         (jump),
        .jump_target_o  (jump_target)
    );

    // Single register stage with handshake
    exec_output_stage u_exec_output_stage (
        .clk            (clk),
        .reset_n        (reset_n),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .req_i          (req_i),
        .alu_result_i   (alu_result),
        .mem_i          (mem_req),
        .jump_i         (jump),
        .jump_target_i  (jump_target),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .rsp_o          (rsp_o)
    );

endmodule

`default_nettype wire
